// ==== wbb_pkg.sv ====
// Shared definitions for the Wishbone bus bridge
// Address, data and line widths, transfer sizes, B4 cycle codes and byte-lane select

package wbb_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  // Byte address on the bus
  typedef logic [31:0] addr_t;
  // One data beat
  typedef logic [31:0] word_t;
  // Byte-lane select, one bit per byte of a word
  typedef logic [3:0] sel_t;

  // Beats per cache line
  localparam int LINE_WORDS = 4;
  // Cache line, word 0 in the low bits
  typedef logic [LINE_WORDS-1:0][31:0] line_t;

  // Access size of a request
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // ====================================================================
  // Wishbone B4 registered-feedback codes
  // ====================================================================
  typedef logic [2:0] cti_t;
  localparam cti_t CTI_CLASSIC = 3'b000;
  localparam cti_t CTI_INCR    = 3'b010;
  localparam cti_t CTI_EOB     = 3'b111;

  typedef logic [1:0] bte_t;
  localparam bte_t BTE_LINEAR = 2'b00;
  localparam bte_t BTE_WRAP4  = 2'b01;

  // Lanes touched by an access of the given size at the given word offset
  function automatic sel_t gen_byte_sel(size_e size, logic [1:0] offset);
    sel_t sel;
    case (size)
      SIZE_BYTE: sel = sel_t'(4'b0001 << offset);
      // Halfwords sit on lane pair 0/1 or 2/3
      SIZE_HALF: sel = offset[1] ? 4'b1100 : 4'b0011;
      default:   sel = 4'b1111;
    endcase
    return sel;
  endfunction

endpackage

// ==== wb_master_bridge.sv ====
// Wishbone B4 master bridge
// Turns line requests into 4-beat incrementing bursts and uncached requests into
// single classic cycles, then returns read data and a completion pulse

module wb_master_bridge import wbb_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Request port
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  input  logic  req_we_i,
  input  size_e req_size_i,
  input  logic  req_uncached_i,
  input  line_t req_wdata_i,

  // Response port
  output logic  res_ready_o,
  output logic  res_valid_o,
  output logic  res_err_o,
  output line_t res_rdata_o,

  // Wishbone master side
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output logic  wb_we_o,
  output addr_t wb_adr_o,
  output word_t wb_dat_o,
  output sel_t  wb_sel_o,
  output cti_t  wb_cti_o,
  output bte_t  wb_bte_o,
  input  logic  wb_ack_i,
  input  logic  wb_err_i,
  input  logic  wb_stall_i,
  input  word_t wb_dat_i
);

  localparam int BEAT_W   = $clog2(LINE_WORDS);
  // First address bit above the line offset
  localparam int LINE_LSB = BEAT_W + 2;

  typedef enum logic [2:0] {
    IDLE,
    SINGLE_REQ,
    SINGLE_WAIT,
    BURST_REQ,
    BURST_DATA,
    ERROR_HANDLE
  } state_e;

  state_e state_q, state_d;

  // Latched request
  addr_t             addr_q;
  line_t             wdata_q;
  sel_t              sel_q;
  logic              we_q;
  logic              unc_q;
  // Burst progress and read buffer
  logic [BEAT_W-1:0] beat_q;
  logic              last_beat;
  line_t             rdata_q;

  logic              is_uncached;
  logic              accept;

  // Sub-word writes cannot be merged into a line, so they go out as single beats
  assign is_uncached = req_uncached_i || (req_we_i && req_size_i != SIZE_WORD);
  assign accept      = (state_q == IDLE) && req_valid_i;
  assign last_beat   = (beat_q == BEAT_W'(LINE_WORDS - 1));

  // ====================================================================
  // FSM
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = is_uncached ? SINGLE_REQ : BURST_REQ;
        end
      end
      // Hold stb and address until the slave drops stall
      SINGLE_REQ: begin
        if (!wb_stall_i) begin
          state_d = SINGLE_WAIT;
        end
      end
      SINGLE_WAIT: begin
        if (wb_ack_i) begin
          state_d = IDLE;
        end else if (wb_err_i) begin
          state_d = ERROR_HANDLE;
        end
      end
      BURST_REQ: begin
        if (!wb_stall_i) begin
          state_d = BURST_DATA;
        end
      end
      // Next beat after each ack, stop at the failing beat on err
      BURST_DATA: begin
        if (wb_ack_i) begin
          state_d = last_beat ? IDLE : BURST_REQ;
        end else if (wb_err_i) begin
          state_d = ERROR_HANDLE;
        end
      end
      ERROR_HANDLE: state_d = IDLE;
      default:      state_d = IDLE;
    endcase
  end

  // Control state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      beat_q  <= '0;
      we_q    <= 1'b0;
      unc_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        beat_q <= '0;
        we_q   <= req_we_i;
        unc_q  <= is_uncached;
      end else if (state_q == BURST_DATA && wb_ack_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // Request payload and read buffer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      // Only uncached writes narrow the lanes
      if (is_uncached && req_we_i) begin
        sel_q <= gen_byte_sel(req_size_i, req_addr_i[1:0]);
      end else begin
        sel_q <= '1;
      end
    end
    if (state_q == BURST_DATA && wb_ack_i && !we_q) begin
      rdata_q[beat_q] <= wb_dat_i;
    end
  end

  // ====================================================================
  // Wishbone outputs, from registered state only
  // ====================================================================
  always_comb begin
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    wb_we_o  = we_q;
    // Single beats always use word 0 of the write line
    wb_dat_o = wdata_q[beat_q];
    wb_sel_o = sel_q;
    wb_cti_o = CTI_CLASSIC;
    wb_bte_o = BTE_LINEAR;
    // Bursts walk the aligned line, single beats keep the request address
    wb_adr_o = unc_q ? addr_q : {addr_q[31:LINE_LSB], beat_q, 2'b00};
    case (state_q)
      SINGLE_REQ: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = 1'b1;
      end
      SINGLE_WAIT: begin
        wb_cyc_o = 1'b1;
      end
      BURST_REQ, BURST_DATA: begin
        wb_cyc_o = 1'b1;
        wb_stb_o = (state_q == BURST_REQ);
        wb_cti_o = last_beat ? CTI_EOB : CTI_INCR;
        wb_bte_o = BTE_WRAP4;
      end
      default: ;
    endcase
  end

  // ====================================================================
  // Response
  // ====================================================================
  assign res_ready_o = (state_q == IDLE);
  assign res_err_o   = (state_q == ERROR_HANDLE);

  always_comb begin
    res_valid_o = 1'b0;
    case (state_q)
      SINGLE_WAIT:  res_valid_o = wb_ack_i;
      BURST_DATA:   res_valid_o = wb_ack_i && last_beat;
      ERROR_HANDLE: res_valid_o = 1'b1;
      default: ;
    endcase
  end

  // Incoming beat bypasses the buffer, the buffer is one cycle late
  always_comb begin
    res_rdata_o = rdata_q;
    if (state_q == SINGLE_WAIT) begin
      // Uncached read word repeated over the line
      for (int k = 0; k < LINE_WORDS; k++) begin
        res_rdata_o[k] = wb_dat_i;
      end
    end else if (state_q == BURST_DATA) begin
      res_rdata_o[beat_q] = wb_dat_i;
    end
  end

  // ====================================================================
  // Assertions
  // ====================================================================
  // No strobe outside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> wb_cyc_o);

  // Requester must honour the ready level
  a_req_when_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> res_ready_o);

  // Completion is a single-cycle pulse
  a_res_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |=> !res_valid_o);

endmodule

// ==== wb_ram_slave.sv ====
// Wishbone B4 on-chip RAM slave
// Registered ack, one stall cycle on a row change, err past the end of the array

module wb_ram_slave import wbb_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  input  logic  wb_cyc_i,
  input  logic  wb_stb_i,
  input  logic  wb_we_i,
  input  addr_t wb_adr_i,
  input  word_t wb_dat_i,
  input  sel_t  wb_sel_i,
  output logic  wb_ack_o,
  output logic  wb_err_o,
  output logic  wb_stall_o,
  output word_t wb_dat_o
);

  localparam int IDX_W   = $clog2(RAM_WORDS);
  // Rows are 64 bytes
  localparam int ROW_LSB = 6;

  word_t mem_q [RAM_WORDS];

  addr_t                word_idx;
  logic [IDX_W-1:0]     mem_idx;
  logic                 in_range;
  logic [31:ROW_LSB]    open_row_q;
  logic                 row_valid_q;
  logic                 row_miss;
  logic                 ack_q;
  logic                 err_q;
  logic                 accept;
  word_t                dat_q;

  assign word_idx = {2'b00, wb_adr_i[31:2]};
  assign mem_idx  = word_idx[IDX_W-1:0];
  assign in_range = (word_idx < addr_t'(RAM_WORDS));

  // Strobed access to a row that is not open
  assign row_miss = wb_cyc_i && wb_stb_i &&
                    (!row_valid_q || wb_adr_i[31:ROW_LSB] != open_row_q);

  // Busy while a response is out or a row is being opened
  assign wb_stall_o = ack_q || err_q || row_miss;
  assign accept     = wb_cyc_i && wb_stb_i && !wb_stall_o;

  // ====================================================================
  // Response and row state
  // ====================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      row_valid_q <= 1'b0;
    end else begin
      ack_q <= accept && in_range;
      err_q <= accept && !in_range;
      if (row_miss) begin
        row_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (row_miss) begin
      open_row_q <= wb_adr_i[31:ROW_LSB];
    end
  end

  // ====================================================================
  // Memory array
  // ====================================================================
  always_ff @(posedge clk_i) begin
    if (accept && in_range) begin
      if (wb_we_i) begin
        // Only selected lanes change
        for (int b = 0; b < 4; b++) begin
          if (wb_sel_i[b]) begin
            mem_q[mem_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
          end
        end
      end else begin
        dat_q <= mem_q[mem_idx];
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign wb_dat_o = dat_q;

  // A beat ends either way, never both
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o));

endmodule

// ==== wbb_top.sv ====
// Bus bridge top level
// Wishbone master bridge in front of an on-chip RAM slave

module wbb_top import wbb_pkg::*; #(
  parameter int RAM_WORDS = 256
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  // Request port
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  input  logic  req_we_i,
  input  size_e req_size_i,
  input  logic  req_uncached_i,
  input  line_t req_wdata_i,

  // Response port
  output logic  res_ready_o,
  output logic  res_valid_o,
  output logic  res_err_o,
  output line_t res_rdata_o
);

  // Wishbone wires between master and slave
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  addr_t wb_adr;
  word_t wb_dat_w;
  sel_t  wb_sel;
  logic  wb_ack;
  logic  wb_err;
  logic  wb_stall;
  word_t wb_dat_r;

  wb_master_bridge u_bridge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_uncached_i (req_uncached_i),
    .req_wdata_i    (req_wdata_i),
    .res_ready_o    (res_ready_o),
    .res_valid_o    (res_valid_o),
    .res_err_o      (res_err_o),
    .res_rdata_o    (res_rdata_o),
    .wb_cyc_o       (wb_cyc),
    .wb_stb_o       (wb_stb),
    .wb_we_o        (wb_we),
    .wb_adr_o       (wb_adr),
    .wb_dat_o       (wb_dat_w),
    .wb_sel_o       (wb_sel),
    // Cycle type and burst type are informational for this RAM
    .wb_cti_o       (),
    .wb_bte_o       (),
    .wb_ack_i       (wb_ack),
    .wb_err_i       (wb_err),
    .wb_stall_i     (wb_stall),
    .wb_dat_i       (wb_dat_r)
  );

  wb_ram_slave #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_sel_i   (wb_sel),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .wb_stall_o (wb_stall),
    .wb_dat_o   (wb_dat_r)
  );

endmodule

// ==== tb_wbb_top.sv ====
// Testbench for the Wishbone bus bridge top level
// Random line and single requests checked against a word-level memory model

module tb_wbb_top import wbb_pkg::*; ();

  localparam int RAM_WORDS = 256;
  localparam int TIMEOUT   = 200;

  logic  clk_i;
  logic  rst_ni;
  logic  req_valid_i;
  addr_t req_addr_i;
  logic  req_we_i;
  size_e req_size_i;
  logic  req_uncached_i;
  line_t req_wdata_i;
  logic  res_ready_o;
  logic  res_valid_o;
  logic  res_err_o;
  line_t res_rdata_o;

  // Reference copy of the RAM, one entry per word
  word_t model_mem [RAM_WORDS];
  int    seed;
  int    pass_cnt;
  int    fail_cnt;

  wbb_top #(
    .RAM_WORDS (RAM_WORDS)
  ) dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_uncached_i (req_uncached_i),
    .req_wdata_i    (req_wdata_i),
    .res_ready_o    (res_ready_o),
    .res_valid_o    (res_valid_o),
    .res_err_o      (res_err_o),
    .res_rdata_o    (res_rdata_o)
  );

  always #4 clk_i = ~clk_i;

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic check_line(input string name, input line_t exp, input line_t got);
    if (exp === got) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
      $display("error %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t got);
    if (exp === got) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
      $display("error %s exp %h got %h", name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (exp === got) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
      $display("error %s exp %h got %h", name, exp, got);
    end
  endtask

  // ====================================================================
  // Model and stimulus helpers
  // ====================================================================
  // Lanes touched by a store: one byte, an aligned lane pair, or the word
  function automatic sel_t lane_mask(input size_e size, input logic [1:0] off);
    sel_t m;
    m = 4'b0000;
    for (int b = 0; b < 4; b++) begin
      case (size)
        SIZE_BYTE: m[b] = (b == int'(off));
        SIZE_HALF: m[b] = ((b / 2) == int'(off[1]));
        default:   m[b] = 1'b1;
      endcase
    end
    return m;
  endfunction

  // Initial RAM contents, all address bits mixed in
  function automatic word_t fill_word(input addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0ff0;
  endfunction

  function automatic line_t rand_line();
    line_t l;
    for (int k = 0; k < LINE_WORDS; k++) begin
      l[k] = $random(seed);
    end
    return l;
  endfunction

  function automatic addr_t rand_addr();
    addr_t a;
    a = $random(seed);
    return a & addr_t'(RAM_WORDS * 4 - 1);
  endfunction

  // Byte address past the last RAM word
  function automatic addr_t oor_addr();
    addr_t a;
    a = $random(seed);
    return addr_t'(RAM_WORDS * 4) | (a & 32'h0000_fffc);
  endfunction

  // Expected outcome of one request, stores go into the model here
  task automatic model_access(input addr_t addr, input logic we, input size_e size,
                              input logic unc, input line_t wdata, output line_t exp_data,
                              output logic exp_err, output logic single);
    addr_t idx;
    int    i;
    sel_t  lanes;
    idx      = addr >> 2;
    exp_data = '0;
    exp_err  = 1'b0;
    single   = unc || (we && size != SIZE_WORD);
    if (!single) begin
      // Whole line, aligned down
      idx = idx & ~addr_t'(LINE_WORDS - 1);
    end
    if (idx >= addr_t'(RAM_WORDS)) begin
      exp_err = 1'b1;
    end else begin
      i = int'(idx);
      if (single && we) begin
        lanes = lane_mask(size, addr[1:0]);
        for (int b = 0; b < 4; b++) begin
          if (lanes[b]) begin
            model_mem[i][8*b +: 8] = wdata[0][8*b +: 8];
          end
        end
      end else if (single) begin
        for (int k = 0; k < LINE_WORDS; k++) begin
          exp_data[k] = model_mem[i];
        end
      end else begin
        for (int k = 0; k < LINE_WORDS; k++) begin
          if (we) begin
            model_mem[i + k] = wdata[k];
          end
          exp_data[k] = model_mem[i + k];
        end
      end
    end
  endtask

  // Wait for ready, hold valid for one edge, then wait for the completion pulse
  task automatic do_request(input addr_t addr, input logic we, input size_e size,
                            input logic unc, input line_t wdata, output line_t rdata,
                            output logic err, output logic done);
    int t;
    rdata = '0;
    err   = 1'b0;
    done  = 1'b0;
    t     = 0;
    @(negedge clk_i);
    while (!res_ready_o && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (!res_ready_o) begin
      fail_cnt++;
      $display("timeout: bridge never became ready for a request at %h", addr);
    end else begin
      @(posedge clk_i);
      req_valid_i    <= 1'b1;
      req_addr_i     <= addr;
      req_we_i       <= we;
      req_size_i     <= size;
      req_uncached_i <= unc;
      req_wdata_i    <= wdata;
      @(posedge clk_i);
      req_valid_i <= 1'b0;
      t = 0;
      @(negedge clk_i);
      while (!res_valid_o && t < TIMEOUT) begin
        @(negedge clk_i);
        t++;
      end
      if (res_valid_o) begin
        rdata = res_rdata_o;
        err   = res_err_o;
        done  = 1'b1;
      end else begin
        fail_cnt++;
        $display("timeout: no completion for the request at %h", addr);
      end
    end
  endtask

  task automatic run_check(input addr_t addr, input logic we, input size_e size,
                           input logic unc, input line_t wdata);
    line_t exp_data;
    logic  exp_err;
    logic  single;
    line_t rdata;
    logic  err;
    logic  done;
    model_access(addr, we, size, unc, wdata, exp_data, exp_err, single);
    do_request(addr, we, size, unc, wdata, rdata, err, done);
    if (done) begin
      check_flag("res_err_o", exp_err, err);
      // Read data only matters for reads that completed without err
      if (!we && !exp_err && single) begin
        for (int k = 0; k < LINE_WORDS; k++) begin
          check_word($sformatf("res_rdata_o[%0d]", k), exp_data[k], rdata[k]);
        end
      end else if (!we && !exp_err) begin
        check_line("res_rdata_o", exp_data, rdata);
      end
    end
  endtask

  task automatic end_test(input int num, input string name, input int fails_before);
    $display("test %0d %s: %s", num, name, (fail_cnt == fails_before) ? "ok" : "failed");
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    int    mark;
    int    kind;
    addr_t a;
    line_t wl;
    size_e sz;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_addr_i     = '0;
    req_we_i       = 1'b0;
    req_size_i     = SIZE_WORD;
    req_uncached_i = 1'b0;
    req_wdata_i    = '0;
    seed           = 32'h0af5_df07;
    pass_cnt       = 0;
    fail_cnt       = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle levels before any request
    mark = fail_cnt;
    @(negedge clk_i);
    check_flag("res_ready_o", 1'b1, res_ready_o);
    check_flag("res_valid_o", 1'b0, res_valid_o);
    end_test(1, "reset state", mark);

    // Fill every line first so that no read sees an unwritten word
    mark = fail_cnt;
    for (int i = 0; i < RAM_WORDS / LINE_WORDS; i++) begin
      for (int k = 0; k < LINE_WORDS; k++) begin
        wl[k] = fill_word(addr_t'(16 * i + 4 * k));
      end
      run_check(addr_t'(16 * i), 1'b1, SIZE_WORD, 1'b0, wl);
    end
    for (int n = 0; n < 20; n++) begin
      a = rand_addr();
      run_check(a, 1'b1, SIZE_WORD, 1'b0, rand_line());
      // Read back through an unaligned address in the same line
      run_check((a & ~addr_t'(15)) | (rand_addr() & addr_t'(15)), 1'b0, SIZE_WORD, 1'b0, '0);
    end
    end_test(2, "line write and read", mark);

    mark = fail_cnt;
    for (int n = 0; n < 30; n++) begin
      a = rand_addr() & ~addr_t'(3);
      run_check(a, 1'b1, SIZE_WORD, 1'b1, rand_line());
      run_check(a, 1'b0, SIZE_WORD, 1'b1, '0);
    end
    end_test(3, "uncached word access", mark);

    // Sub-word stores flagged as cached still go out as single beats
    mark = fail_cnt;
    for (int n = 0; n < 30; n++) begin
      a  = rand_addr();
      sz = a[4] ? SIZE_BYTE : SIZE_HALF;
      if (sz == SIZE_HALF) begin
        a[0] = 1'b0;
      end
      run_check(a, 1'b1, sz, 1'b0, rand_line());
      run_check(a & ~addr_t'(3), 1'b0, SIZE_WORD, 1'b1, '0);
    end
    end_test(4, "byte and halfword writes", mark);

    mark = fail_cnt;
    for (int n = 0; n < 6; n++) begin
      a = oor_addr();
      run_check(a, 1'b1, SIZE_WORD, 1'b1, rand_line());
      run_check(a, 1'b1, SIZE_WORD, 1'b0, rand_line());
      run_check(a, 1'b0, SIZE_WORD, 1'b1, '0);
      run_check(a, 1'b0, SIZE_WORD, 1'b0, '0);
      // The line that the low address bits alias must be untouched
      run_check(a & addr_t'(RAM_WORDS * 4 - 1), 1'b0, SIZE_WORD, 1'b0, '0);
    end
    end_test(5, "out of range access", mark);

    // Mixed stream across rows, one in eight out of range
    mark = fail_cnt;
    for (int n = 0; n < 200; n++) begin
      kind = $random(seed);
      a    = (kind[5:3] == 3'd0) ? oor_addr() : rand_addr();
      case (kind[2:0])
        3'd0, 3'd1: run_check(a, 1'b0, SIZE_WORD, 1'b0, '0);
        3'd2:       run_check(a, 1'b1, SIZE_WORD, 1'b0, rand_line());
        3'd3:       run_check(a & ~addr_t'(3), 1'b1, SIZE_WORD, 1'b1, rand_line());
        3'd4:       run_check(a, 1'b0, SIZE_WORD, 1'b1, '0);
        3'd5:       run_check(a, 1'b1, SIZE_BYTE, 1'b0, rand_line());
        3'd6:       run_check(a & ~addr_t'(1), 1'b1, SIZE_HALF, 1'b0, rand_line());
        default:    run_check(a, 1'b0, SIZE_BYTE, 1'b1, '0);
      endcase
    end
    end_test(6, "mixed random stream", mark);

    $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== wbb.f ====
wbb_pkg.sv
wb_master_bridge.sv
wb_ram_slave.sv
wbb_top.sv
tb_wbb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_wbb_top \
  -f wbb.f -o tb_wbb_top \
  && ./obj_dir/tb_wbb_top | tee /dev/stderr | grep -q "^RESULT: PASS$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0
